// ==== rtl/bt_uart_pkg.sv ====
package bt_uart_pkg;

	// 1 MHz clock, roughly 9600 baud
	localparam int clks_per_bit = 104;

	// 8N1 frames only
	localparam int data_bits = 8;

	localparam int baud_cnt_bits = $clog2(clks_per_bit);
	localparam int bit_cnt_bits = $clog2(data_bits);

	// state codes shared by the receive and transmit FSMs
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_start = 2'd1;
	localparam logic [1:0] st_data = 2'd2;
	localparam logic [1:0] st_stop = 2'd3;

	// one received frame
	typedef struct packed {
		logic [data_bits-1:0] data;
		// stop bit was sampled low
		logic                 frame_error;
	} rx_byte_t;

endpackage

// ==== rtl/bt_host_pkg.sv ====
package bt_host_pkg;

	localparam int fifo_depth = 16;
	localparam int count_bits = 5;
	localparam int ptr_bits = $clog2(fifo_depth);

	// trigger-in 0x40 bit positions
	localparam int trig_send = 0;
	localparam int trig_ctrl = 1;
	localparam int trig_pop = 2;

	// wire-in 0x01 as read on trig_send
	typedef struct packed {
		logic [7:0] pad;
		logic [7:0] tx_byte;
	} host_tx_word_t;

	// wire-in 0x01 as read on trig_ctrl
	typedef struct packed {
		logic [13:0] pad;
		logic        clear_rx;
		logic        bt_enable;
	} host_ctrl_word_t;

	typedef union packed {
		host_tx_word_t   tx;
		host_ctrl_word_t ctrl;
	} host_wire_in_u;

	// wire-out 0x20
	typedef struct packed {
		logic [3:0]            pad;
		logic                  bt_state;
		logic                  bt_enable;
		logic                  tx_busy;
		logic                  tx_dropped;
		logic                  rx_empty;
		logic                  rx_full;
		logic                  rx_overflow;
		logic [count_bits-1:0] count;
	} host_status_t;

	// wire-out 0x21
	typedef struct packed {
		logic [6:0] pad;
		logic       head_valid;
		logic [7:0] head;
	} host_rx_word_t;

	// wire-out 0x22, both fields saturate
	typedef struct packed {
		logic [7:0] frame_errors;
		logic [7:0] tx_bytes;
	} host_counts_t;

endpackage

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  rxd,
	output bt_uart_pkg::rx_byte_t rx_byte,
	output logic                  rx_valid,
	output logic                  frame_error
);
	import bt_uart_pkg::*;

	logic                     rxd_meta;
	logic                     rxd_sync;
	logic                     rxd_last;
	logic [1:0]               state;
	logic [baud_cnt_bits-1:0] baud_cnt;
	logic [bit_cnt_bits-1:0]  bit_cnt;
	logic [data_bits-1:0]     shift;
	logic                     sample;

	// two-flop synchronizer, held at the idle level in reset
	always_ff @(posedge clock) begin
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_last <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_last <= rxd_sync;
		end
	end

	// countdown hits zero at mid-bit
	assign sample = (baud_cnt == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			baud_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			frame_error <= 1'b0;
			case (state)
				st_idle: begin
					// falling edge of the start bit, aim at its middle
					if (rxd_last && !rxd_sync) begin
						state <= st_start;
						baud_cnt <= baud_cnt_bits'(clks_per_bit / 2 - 1);
					end
				end
				st_start: begin
					if (!sample) begin
						baud_cnt <= baud_cnt - 1'b1;
					end else if (!rxd_sync) begin
						state <= st_data;
						baud_cnt <= baud_cnt_bits'(clks_per_bit - 1);
						bit_cnt <= '0;
					end else begin
						// glitch, not a real start bit
						state <= st_idle;
					end
				end
				st_data: begin
					if (!sample) begin
						baud_cnt <= baud_cnt - 1'b1;
					end else begin
						baud_cnt <= baud_cnt_bits'(clks_per_bit - 1);
						if (bit_cnt == bit_cnt_bits'(data_bits - 1))
							state <= st_stop;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: begin
					if (!sample) begin
						baud_cnt <= baud_cnt - 1'b1;
					end else begin
						rx_valid <= rxd_sync;
						frame_error <= !rxd_sync;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clock) begin
		if (state == st_data && sample)
			shift <= {rxd_sync, shift[data_bits-1:1]};
		if (state == st_stop && sample) begin
			rx_byte.data <= shift;
			rx_byte.frame_error <= !rxd_sync;
		end
	end

	assert property (@(posedge clock) disable iff (reset) !(rx_valid && frame_error));

endmodule

// ==== rtl/rx_fifo.sv ====
`timescale 1ns/1ns

module rx_fifo (
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             push,
	input  logic [7:0]                       push_byte,
	input  logic                             pop,
	input  logic                             clear,
	output logic [7:0]                       head,
	output logic                             head_valid,
	output logic [bt_host_pkg::count_bits-1:0] count,
	output logic                             full,
	output logic                             overflow
);
	import bt_host_pkg::*;

	logic [7:0]          mem [fifo_depth];
	logic [ptr_bits-1:0] wr_ptr;
	logic [ptr_bits-1:0] rd_ptr;
	logic                do_push;
	logic                do_pop;

	assign head_valid = (count != '0);
	assign full = (count == count_bits'(fifo_depth));
	// first word falls through
	assign head = mem[rd_ptr];

	// pops on an empty queue are dropped
	assign do_pop = pop && head_valid;
	// a full queue still takes a byte if one leaves in the same cycle
	assign do_push = push && (!full || do_pop);

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_byte;
	end

	always_ff @(posedge clock) begin
		if (reset || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// sticky until the host clears
			if (push && !do_push)
				overflow <= 1'b1;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		count <= count_bits'(fifo_depth));

	// empty means the write pointer has not moved past the read pointer
	assert property (@(posedge clock) disable iff (reset)
		!head_valid |-> (wr_ptr == rd_ptr));

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
	input  logic       clock,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       txd,
	output logic       tx_busy
);
	import bt_uart_pkg::*;

	logic [1:0]               state;
	logic [baud_cnt_bits-1:0] baud_cnt;
	logic [bit_cnt_bits-1:0]  bit_cnt;
	logic [data_bits-1:0]     shift;
	logic                     bit_done;

	assign bit_done = (baud_cnt == '0);
	// busy through the end of the stop bit
	assign tx_busy = (state != st_idle);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
			baud_cnt <= '0;
			bit_cnt <= '0;
			txd <= 1'b1;
		end else if (state == st_idle) begin
			if (tx_start) begin
				txd <= 1'b0;
				baud_cnt <= baud_cnt_bits'(clks_per_bit - 1);
				state <= st_start;
			end
		end else if (!bit_done) begin
			baud_cnt <= baud_cnt - 1'b1;
		end else begin
			baud_cnt <= baud_cnt_bits'(clks_per_bit - 1);
			case (state)
				st_start: begin
					txd <= shift[0];
					bit_cnt <= '0;
					state <= st_data;
				end
				st_data: begin
					if (bit_cnt == bit_cnt_bits'(data_bits - 1)) begin
						txd <= 1'b1;
						state <= st_stop;
					end else begin
						txd <= shift[0];
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// lsb first, next bit always sits in shift[0]
	always_ff @(posedge clock) begin
		if (state == st_idle && tx_start)
			shift <= tx_data;
		else if ((state == st_start || state == st_data) && bit_done)
			shift <= shift >> 1;
	end

	assert property (@(posedge clock) disable iff (reset) !tx_busy |-> txd);

endmodule

// ==== rtl/host_endpoints.sv ====
`timescale 1ns/1ns

module host_endpoints (
	input  logic                               clock,
	input  logic                               reset,
	input  bt_host_pkg::host_wire_in_u         wire_in,
	input  logic [15:0]                        trig_in,
	input  logic                               bt_state,
	input  logic [7:0]                         rx_head,
	input  logic                               rx_head_valid,
	input  logic                               rx_full,
	input  logic                               rx_overflow,
	input  logic [bt_host_pkg::count_bits-1:0] rx_count,
	input  logic                               frame_error,
	input  logic                               tx_busy,
	output logic                               tx_start,
	output logic [7:0]                         tx_data,
	output logic                               rx_pop,
	output logic                               rx_clear,
	output logic                               bt_enable,
	output bt_host_pkg::host_status_t          status,
	output bt_host_pkg::host_rx_word_t         rx_word,
	output bt_host_pkg::host_counts_t          counts
);
	import bt_host_pkg::*;

	logic       send_fire;
	logic       ctrl_fire;
	logic       tx_dropped;
	logic [7:0] frame_err_count;
	logic [7:0] tx_count;

	assign send_fire = trig_in[trig_send];
	assign ctrl_fire = trig_in[trig_ctrl];

	// same wire-in word, decoded by whichever trigger fired
	assign tx_start = send_fire && !tx_busy;
	assign tx_data = wire_in.tx.tx_byte;
	assign rx_clear = ctrl_fire && wire_in.ctrl.clear_rx;
	assign rx_pop = trig_in[trig_pop];

	always_ff @(posedge clock) begin
		if (reset) begin
			bt_enable <= 1'b0;
			tx_dropped <= 1'b0;
			frame_err_count <= '0;
			tx_count <= '0;
		end else begin
			if (ctrl_fire)
				bt_enable <= wire_in.ctrl.bt_enable;
			if (rx_clear)
				tx_dropped <= 1'b0;
			else if (send_fire && tx_busy)
				tx_dropped <= 1'b1;
			// both counters stick at 255
			if (frame_error && frame_err_count != 8'hff)
				frame_err_count <= frame_err_count + 8'd1;
			if (tx_start && tx_count != 8'hff)
				tx_count <= tx_count + 8'd1;
		end
	end

	always_comb begin
		status = '0;
		status.bt_state = bt_state;
		status.bt_enable = bt_enable;
		status.tx_busy = tx_busy;
		status.tx_dropped = tx_dropped;
		status.rx_empty = !rx_head_valid;
		status.rx_full = rx_full;
		status.rx_overflow = rx_overflow;
		status.count = rx_count;

		// stale memory contents stay hidden when empty
		rx_word = '0;
		rx_word.head_valid = rx_head_valid;
		rx_word.head = rx_head_valid ? rx_head : 8'h00;

		counts.frame_errors = frame_err_count;
		counts.tx_bytes = tx_count;
	end

endmodule

// ==== rtl/fpga_bluetooth_connection.sv ====
`timescale 1ns/1ns

module fpga_bluetooth_connection (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       bt_state,
	input  logic                       fpga_rxd,
	output logic                       fpga_txd,
	output logic                       bt_enable,
	input  bt_host_pkg::host_wire_in_u ep01_wire_in,
	input  logic [15:0]                ep40_trig_in,
	output bt_host_pkg::host_status_t  ep20_wire_out,
	output bt_host_pkg::host_rx_word_t ep21_wire_out,
	output bt_host_pkg::host_counts_t  ep22_wire_out
);
	import bt_uart_pkg::*;
	import bt_host_pkg::*;

	rx_byte_t              rx_byte;
	logic                  rx_valid;
	logic                  frame_error;
	logic [7:0]            rx_head;
	logic                  rx_head_valid;
	logic [count_bits-1:0] rx_count;
	logic                  rx_full;
	logic                  rx_overflow;
	logic                  rx_pop;
	logic                  rx_clear;
	logic                  tx_start;
	logic [7:0]            tx_data;
	logic                  tx_busy;

	// module serial output into the fabric
	uart_rx rx (
		.clock(clock),
		.reset(reset),
		.rxd(fpga_rxd),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.frame_error(frame_error)
	);

	// only good frames reach the queue
	rx_fifo fifo (
		.clock(clock),
		.reset(reset),
		.push(rx_valid),
		.push_byte(rx_byte.data),
		.pop(rx_pop),
		.clear(rx_clear),
		.head(rx_head),
		.head_valid(rx_head_valid),
		.count(rx_count),
		.full(rx_full),
		.overflow(rx_overflow)
	);

	host_endpoints host (
		.clock(clock),
		.reset(reset),
		.wire_in(ep01_wire_in),
		.trig_in(ep40_trig_in),
		.bt_state(bt_state),
		.rx_head(rx_head),
		.rx_head_valid(rx_head_valid),
		.rx_full(rx_full),
		.rx_overflow(rx_overflow),
		.rx_count(rx_count),
		.frame_error(frame_error),
		.tx_busy(tx_busy),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.rx_pop(rx_pop),
		.rx_clear(rx_clear),
		.bt_enable(bt_enable),
		.status(ep20_wire_out),
		.rx_word(ep21_wire_out),
		.counts(ep22_wire_out)
	);

	uart_tx tx (
		.clock(clock),
		.reset(reset),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.txd(fpga_txd),
		.tx_busy(tx_busy)
	);

endmodule

// ==== test/tb_fpga_bluetooth.sv ====
`timescale 1ns/1ns

module tb_fpga_bluetooth;
	import bt_uart_pkg::*;
	import bt_host_pkg::*;

	localparam int settle_limit = 4 * clks_per_bit;

	logic            clock;
	logic            reset;
	logic            bt_state;
	logic            fpga_rxd;
	logic            fpga_txd;
	logic            bt_enable;
	host_wire_in_u   ep01_wire_in;
	logic [15:0]     ep40_trig_in;
	host_status_t    ep20_wire_out;
	host_rx_word_t   ep21_wire_out;
	host_counts_t    ep22_wire_out;

	// reference model state
	logic [7:0]      ref_q [$];
	logic            ref_overflow;
	logic            ref_dropped;
	logic            ref_enable;
	logic [7:0]      ref_frame_errs;
	logic [7:0]      ref_tx_count;
	logic [31:0]     rng_state;

	fpga_bluetooth_connection uut (
		.clock(clock),
		.reset(reset),
		.bt_state(bt_state),
		.fpga_rxd(fpga_rxd),
		.fpga_txd(fpga_txd),
		.bt_enable(bt_enable),
		.ep01_wire_in(ep01_wire_in),
		.ep40_trig_in(ep40_trig_in),
		.ep20_wire_out(ep20_wire_out),
		.ep21_wire_out(ep21_wire_out),
		.ep22_wire_out(ep22_wire_out)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_byte(output logic [7:0] b);
		rng_state = xorshift32(rng_state);
		b = rng_state[7:0];
	endtask

	// expected wire-outs, tx assumed idle
	function automatic host_status_t expected_status();
		host_status_t s;
		s = '0;
		s.bt_state = bt_state;
		s.bt_enable = ref_enable;
		s.tx_dropped = ref_dropped;
		s.rx_empty = (ref_q.size() == 0);
		s.rx_full = (ref_q.size() == fifo_depth);
		s.rx_overflow = ref_overflow;
		s.count = count_bits'(ref_q.size());
		return s;
	endfunction

	function automatic host_rx_word_t expected_rx_word();
		host_rx_word_t w;
		w = '0;
		if (ref_q.size() != 0) begin
			w.head_valid = 1'b1;
			w.head = ref_q[0];
		end
		return w;
	endfunction

	function automatic host_counts_t expected_counts();
		host_counts_t c;
		c.frame_errors = ref_frame_errs;
		c.tx_bytes = ref_tx_count;
		return c;
	endfunction

	task automatic fail_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic fail_plain(input string what);
		$display("ERROR: %s", what);
		fail_run();
	endtask

	task automatic check_status(input string name, input host_status_t exp,
		input host_status_t act);
		if (act !== exp) begin
			$display("MISMATCH %s status expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_rx_word(input string name, input host_rx_word_t exp,
		input host_rx_word_t act);
		if (act !== exp) begin
			$display("MISMATCH %s rx word expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_counts(input string name, input host_counts_t exp,
		input host_counts_t act);
		if (act !== exp) begin
			$display("MISMATCH %s counts expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_tx_byte(input string name, input logic [7:0] exp,
		input logic [7:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s tx byte expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	// wait for the wire-outs to reach the model, then compare
	task automatic wait_for_outputs(input string name);
		int cycles;
		cycles = 0;
		while ((ep20_wire_out !== expected_status() || ep21_wire_out !== expected_rx_word()
			|| ep22_wire_out !== expected_counts()) && cycles < settle_limit) begin
			@(negedge clock);
			cycles++;
		end
		check_status(name, expected_status(), ep20_wire_out);
		check_rx_word(name, expected_rx_word(), ep21_wire_out);
		check_counts(name, expected_counts(), ep22_wire_out);
	endtask

	task automatic pulse_trigger(input int bit_pos, input host_wire_in_u word);
		@(negedge clock);
		ep01_wire_in = word;
		ep40_trig_in = 16'(1) << bit_pos;
		@(negedge clock);
		ep40_trig_in = '0;
	endtask

	task automatic write_ctrl(input logic enable, input logic clear);
		host_wire_in_u w;
		w = '0;
		w.ctrl.bt_enable = enable;
		w.ctrl.clear_rx = clear;
		pulse_trigger(trig_ctrl, w);
		ref_enable = enable;
		if (clear) begin
			ref_q.delete();
			ref_overflow = 1'b0;
			ref_dropped = 1'b0;
		end
	endtask

	task automatic write_send(input logic [7:0] b);
		host_wire_in_u w;
		w = '0;
		w.tx.tx_byte = b;
		pulse_trigger(trig_send, w);
	endtask

	task automatic pop_rx();
		pulse_trigger(trig_pop, ep01_wire_in);
		void'(ref_q.pop_front());
	endtask

	// line model for the module's serial output, 8N1
	task automatic send_serial(input logic [7:0] data, input logic stop_level);
		@(negedge clock);
		fpga_rxd = 1'b0;
		repeat (clks_per_bit) @(negedge clock);
		for (int i = 0; i < data_bits; i++) begin
			fpga_rxd = data[i];
			repeat (clks_per_bit) @(negedge clock);
		end
		fpga_rxd = stop_level;
		repeat (clks_per_bit) @(negedge clock);
		fpga_rxd = 1'b1;
		if (stop_level) begin
			if (ref_q.size() == fifo_depth)
				ref_overflow = 1'b1;
			else
				ref_q.push_back(data);
		end else begin
			ref_frame_errs = ref_frame_errs + 8'd1;
		end
	endtask

	// samples each bit of one frame on fpga_txd at mid-bit
	task automatic capture_tx_byte(output logic [7:0] b);
		int cycles;
		cycles = 0;
		while (fpga_txd !== 1'b0 && cycles < settle_limit) begin
			@(negedge clock);
			cycles++;
		end
		if (fpga_txd !== 1'b0)
			fail_plain("no start bit appeared on fpga_txd");
		repeat (clks_per_bit / 2) @(negedge clock);
		if (fpga_txd !== 1'b0)
			fail_plain("start bit on fpga_txd did not last to mid-bit");
		if (ep20_wire_out.tx_busy !== 1'b1)
			fail_plain("tx_busy in status was low during the start bit");
		for (int i = 0; i < data_bits; i++) begin
			repeat (clks_per_bit) @(negedge clock);
			b[i] = fpga_txd;
		end
		repeat (clks_per_bit) @(negedge clock);
		if (fpga_txd !== 1'b1)
			fail_plain("stop bit on fpga_txd was low");
	endtask

	initial begin
		logic [7:0] b;
		logic [7:0] got;
		logic [7:0] second;

		reset = 1'b1;
		bt_state = 1'b1;
		fpga_rxd = 1'b1;
		ep01_wire_in = '0;
		ep40_trig_in = '0;
		ref_overflow = 1'b0;
		ref_dropped = 1'b0;
		ref_enable = 1'b0;
		ref_frame_errs = '0;
		ref_tx_count = '0;
		rng_state = 32'h72cb;
		repeat (8) @(negedge clock);
		reset = 1'b0;

		// reset state, then enable the module
		wait_for_outputs("reset_state");
		if (fpga_txd !== 1'b1)
			fail_plain("fpga_txd is not high after reset");
		write_ctrl(1'b1, 1'b0);
		wait_for_outputs("enable");
		if (bt_enable !== 1'b1)
			fail_plain("bt_enable pin did not follow the control write");

		for (int n = 0; n < 4; n++) begin
			next_byte(b);
			write_send(b);
			capture_tx_byte(got);
			check_tx_byte("transmit", b, got);
			ref_tx_count = ref_tx_count + 8'd1;
			wait_for_outputs("transmit");
		end

		for (int n = 0; n < 6; n++) begin
			next_byte(b);
			send_serial(b, 1'b1);
			wait_for_outputs("receive_order");
		end
		while (ref_q.size() != 0) begin
			pop_rx();
			wait_for_outputs("receive_order_pop");
		end

		// 17th byte finds the queue full
		for (int n = 0; n < fifo_depth + 1; n++) begin
			next_byte(b);
			send_serial(b, 1'b1);
			wait_for_outputs("overflow_fill");
		end
		while (ref_q.size() != 0) begin
			pop_rx();
			wait_for_outputs("overflow_drain");
		end
		next_byte(b);
		send_serial(b, 1'b1);
		next_byte(b);
		send_serial(b, 1'b1);
		wait_for_outputs("before_clear");
		write_ctrl(1'b1, 1'b1);
		wait_for_outputs("clear");

		next_byte(b);
		send_serial(b, 1'b0);
		wait_for_outputs("framing_error");

		// second send lands while the first frame is on the line
		next_byte(b);
		next_byte(second);
		write_send(b);
		fork
			capture_tx_byte(got);
			begin
				repeat (20) @(negedge clock);
				write_send(second);
			end
		join
		check_tx_byte("busy_drop", b, got);
		ref_tx_count = ref_tx_count + 8'd1;
		ref_dropped = 1'b1;
		wait_for_outputs("busy_drop");
		repeat (2 * clks_per_bit) begin
			@(negedge clock);
			if (fpga_txd !== 1'b1)
				fail_plain("dropped byte was sent on fpga_txd");
		end
		wait_for_outputs("busy_drop_idle");

		// clear_rx also drops the sticky tx_dropped flag
		write_ctrl(1'b1, 1'b1);
		wait_for_outputs("clear_dropped");

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== fpga_bluetooth.f ====
rtl/bt_uart_pkg.sv
rtl/bt_host_pkg.sv
rtl/uart_rx.sv
rtl/rx_fifo.sv
rtl/uart_tx.sv
rtl/host_endpoints.sv
rtl/fpga_bluetooth_connection.sv
test/tb_fpga_bluetooth.sv
